/* verilog/tcp_pkg.sv */
package tcp_pkg;

	typedef logic [31:0] seq_t;   // sequence or ack number
	typedef logic [15:0] port_t;  // tcp port
	typedef logic [7:0]  flags_t; // raw flag byte, bit order below

	// flag bit positions inside flags_t
	localparam int FLAG_FIN = 0;
	localparam int FLAG_SYN = 1;
	localparam int FLAG_RST = 2;
	localparam int FLAG_PSH = 3;
	localparam int FLAG_ACK = 4;

	localparam int    HDR_BYTES = 20;           // no options, offset always 5
	localparam port_t LOC_PORT  = 16'd80;       // listening port
	localparam seq_t  ISN       = 32'h5eed_0000; // our initial sequence number
	localparam logic [15:0] WINDOW = 16'd1024;  // advertised, never changes

	localparam int QUEUE_AW   = 8;    // 256 byte tx buffer
	localparam int MSS        = 64;   // max payload bytes per segment
	localparam int WAIT_TICKS = 32;   // idle cycles before a short segment goes out
	localparam int RETX_TICKS = 2000; // cycles without ack before resend

	typedef enum logic [2:0] {
		LISTEN,
		SYN_RCVD,
		ESTABLISHED,
		LAST_ACK,
		CLOSED
	} state_t;

	// buffer slot of a sequence number, first data byte is ISN+1
	function automatic logic [QUEUE_AW-1:0] buf_addr(input seq_t s);
		seq_t off;
		off = s - (ISN + 32'd1);
		return off[QUEUE_AW-1:0];
	endfunction

endpackage

/* verilog/tcp_rx_parser.sv */
module tcp_rx_parser (
	input  logic             clk,
	input  logic             reset,
	input  logic [7:0]       rx_d,
	input  logic             rx_v,
	input  logic             rx_sof,
	input  logic             rx_eof,
	output logic             hdr_v,
	output tcp_pkg::port_t   src_port,
	output tcp_pkg::port_t   dst_port,
	output tcp_pkg::seq_t    seg_seq,
	output tcp_pkg::seq_t    seg_ack,
	output tcp_pkg::flags_t  seg_flags,
	output logic [15:0]      seg_len
);

	logic [15:0] cnt; // bytes seen so far in this segment
	logic [15:0] idx; // index of the byte on rx_d
	logic        hdr_ok;

	// working copies, shifted in msb first
	tcp_pkg::port_t  w_src;
	tcp_pkg::port_t  w_dst;
	tcp_pkg::seq_t   w_seq;
	tcp_pkg::seq_t   w_ack;
	tcp_pkg::flags_t w_flags;

	assign idx = rx_sof ? 16'd0 : cnt; // sof restarts the count
	// last byte of a segment long enough to hold a header
	assign hdr_ok = rx_v && rx_eof && (idx >= 16'(tcp_pkg::HDR_BYTES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt   <= '0;
			hdr_v <= 1'b0;
		end else begin
			hdr_v <= hdr_ok; // one cycle after the eof byte
			if (rx_v && idx != 16'hffff)
				cnt <= idx + 16'd1;
		end
	end

	// field steering by byte position
	always_ff @(posedge clk) begin
		if (rx_v) begin
			case (idx)
				16'd0, 16'd1:                 w_src <= {w_src[7:0], rx_d};
				16'd2, 16'd3:                 w_dst <= {w_dst[7:0], rx_d};
				16'd4, 16'd5, 16'd6, 16'd7:   w_seq <= {w_seq[23:0], rx_d};
				16'd8, 16'd9, 16'd10, 16'd11: w_ack <= {w_ack[23:0], rx_d};
				16'd13:                       w_flags <= rx_d;
				default: ; // offset, window, checksum, urgent ignored
			endcase
		end
		// publish, held until the next good segment
		if (hdr_ok) begin
			src_port  <= w_src;
			dst_port  <= w_dst;
			seg_seq   <= w_seq;
			seg_ack   <= w_ack;
			seg_flags <= w_flags;
			seg_len   <= idx + 16'd1 - 16'(tcp_pkg::HDR_BYTES); // payload bytes only
		end
	end

endmodule

/* verilog/tcp_conn_fsm.sv */
module tcp_conn_fsm (
	input  logic             clk,
	input  logic             reset,
	input  logic             listen,
	input  logic             hdr_v,
	input  tcp_pkg::port_t   src_port,
	input  tcp_pkg::port_t   dst_port,
	input  tcp_pkg::seq_t    seg_seq,
	input  tcp_pkg::seq_t    seg_ack,
	input  tcp_pkg::flags_t  seg_flags,
	input  logic [15:0]      seg_len,
	output logic             connected,
	output logic             ctl_req,
	output tcp_pkg::flags_t  ctl_flags,
	output tcp_pkg::seq_t    snd_seq,
	output tcp_pkg::seq_t    rcv_ack,
	output tcp_pkg::port_t   rem_port,
	output logic             ack_v,
	output tcp_pkg::seq_t    ack_num
);

	tcp_pkg::state_t state;
	logic            listen_q; // for the rising edge in CLOSED
	logic            for_us;   // new header addressed to our port
	logic            from_rem; // and from the connected peer
	logic            in_order;
	logic            f_syn, f_ack, f_fin, f_rst;

	// control segment flags, always with ACK
	function automatic tcp_pkg::flags_t ctl_mask(input logic syn, input logic fin);
		tcp_pkg::flags_t f;
		f = '0;
		f[tcp_pkg::FLAG_ACK] = 1'b1;
		f[tcp_pkg::FLAG_SYN] = syn;
		f[tcp_pkg::FLAG_FIN] = fin;
		return f;
	endfunction

	assign f_syn = seg_flags[tcp_pkg::FLAG_SYN];
	assign f_ack = seg_flags[tcp_pkg::FLAG_ACK];
	assign f_fin = seg_flags[tcp_pkg::FLAG_FIN];
	assign f_rst = seg_flags[tcp_pkg::FLAG_RST];

	assign for_us   = hdr_v && (dst_port == tcp_pkg::LOC_PORT);
	assign from_rem = for_us && (src_port == rem_port);
	assign in_order = (seg_seq == rcv_ack); // no reassembly, only next expected byte

	// peer may still send its last ACK in LAST_ACK, keep queue alive until then
	assign connected = (state == tcp_pkg::ESTABLISHED) || (state == tcp_pkg::LAST_ACK);

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= tcp_pkg::LISTEN;
			listen_q  <= 1'b0;
			ctl_req   <= 1'b0;
			ctl_flags <= '0;
			ack_v     <= 1'b0;
			ack_num   <= '0;
			snd_seq   <= tcp_pkg::ISN;
			rcv_ack   <= '0;
			rem_port  <= '0;
		end else begin
			listen_q <= listen;
			ctl_req  <= 1'b0; // pulses
			ack_v    <= 1'b0;
			case (state)
				tcp_pkg::LISTEN: begin
					if (for_us && listen && f_syn && !f_rst) begin
						rem_port  <= src_port;
						rcv_ack   <= seg_seq + 32'd1; // syn takes one number
						snd_seq   <= tcp_pkg::ISN;
						ctl_flags <= ctl_mask(1'b1, 1'b0);
						ctl_req   <= 1'b1;
						state     <= tcp_pkg::SYN_RCVD;
					end
				end
				tcp_pkg::SYN_RCVD: begin
					if (from_rem) begin
						if (f_rst)
							state <= tcp_pkg::LISTEN;
						else if (f_syn) begin // our syn|ack got lost
							ctl_flags <= ctl_mask(1'b1, 1'b0);
							ctl_req   <= 1'b1;
						end else if (f_ack && seg_ack == tcp_pkg::ISN + 32'd1) begin
							snd_seq <= tcp_pkg::ISN + 32'd1;
							state   <= tcp_pkg::ESTABLISHED;
						end
					end
				end
				tcp_pkg::ESTABLISHED: begin
					if (from_rem) begin
						if (f_rst)
							state <= tcp_pkg::LISTEN;
						else begin
							if (f_ack) begin
								ack_v   <= 1'b1; // queue frees acked bytes
								ack_num <= seg_ack;
								snd_seq <= seg_ack;
							end
							if (f_fin && in_order) begin
								rcv_ack   <= rcv_ack + 32'(seg_len) + 32'd1;
								ctl_flags <= ctl_mask(1'b0, 1'b1);
								ctl_req   <= 1'b1;
								state     <= tcp_pkg::LAST_ACK;
							end else if (seg_len != 16'd0) begin
								if (in_order)
									rcv_ack <= rcv_ack + 32'(seg_len);
								ctl_flags <= ctl_mask(1'b0, 1'b0); // dup ack if out of order
								ctl_req   <= 1'b1;
							end
						end
					end
				end
				tcp_pkg::LAST_ACK: begin
					// our fin used one number
					if (from_rem && (f_rst || (f_ack && seg_ack == snd_seq + 32'd1)))
						state <= tcp_pkg::CLOSED;
				end
				tcp_pkg::CLOSED: begin
					if (listen && !listen_q)
						state <= tcp_pkg::LISTEN;
				end
				default: state <= tcp_pkg::LISTEN;
			endcase
		end
	end

endmodule

/* verilog/tcp_tx_queue.sv */
module tcp_tx_queue (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [7:0]                   din,
	input  logic                         vin,
	input  logic                         connected,
	input  logic                         ack_v,
	input  tcp_pkg::seq_t                ack_num,
	input  logic [tcp_pkg::QUEUE_AW-1:0] rd_addr,
	input  logic                         seg_done,
	output logic                         cts,
	output logic                         seg_req,
	output tcp_pkg::seq_t                seg_seq,
	output logic [15:0]                  seg_len,
	output logic [7:0]                   rd_data
);

	logic [7:0] mem [0:2**tcp_pkg::QUEUE_AW-1];

	// pointers kept as absolute sequence numbers
	tcp_pkg::seq_t base_seq; // oldest unacked byte
	tcp_pkg::seq_t sent_seq; // next byte to send
	tcp_pkg::seq_t wr_seq;   // next free slot
	tcp_pkg::seq_t used, unsent, acked;
	logic [15:0]   ready_len, retx_len;
	logic [15:0]   wait_cnt, retx_cnt;
	logic          conn_q;
	logic          wr_en;

	assign used   = wr_seq - base_seq;
	assign unsent = wr_seq - sent_seq;
	assign acked  = ack_num - base_seq; // bytes the ack would free
	assign cts    = used < 32'(2**tcp_pkg::QUEUE_AW);
	assign wr_en  = vin && cts; // writes while full are dropped

	assign ready_len = (unsent >= 32'(tcp_pkg::MSS)) ? 16'(tcp_pkg::MSS) : unsent[15:0];
	assign retx_len  = (used >= 32'(tcp_pkg::MSS)) ? 16'(tcp_pkg::MSS) : used[15:0];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[tcp_pkg::buf_addr(wr_seq)] <= din;
		rd_data <= mem[rd_addr]; // one cycle read for the builder
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			base_seq <= tcp_pkg::ISN + 32'd1;
			sent_seq <= tcp_pkg::ISN + 32'd1;
			wr_seq   <= tcp_pkg::ISN + 32'd1;
			seg_req  <= 1'b0;
			wait_cnt <= '0;
			retx_cnt <= '0;
			conn_q   <= 1'b0;
		end else begin
			conn_q <= connected;
			if (wr_en)
				wr_seq <= wr_seq + 32'd1;
			if (conn_q && !connected) begin // connection gone, drop everything
				base_seq <= tcp_pkg::ISN + 32'd1;
				sent_seq <= tcp_pkg::ISN + 32'd1;
				wr_seq   <= tcp_pkg::ISN + 32'd1;
				seg_req  <= 1'b0;
				wait_cnt <= '0;
				retx_cnt <= '0;
			end else begin
				// idle time of the unsent tail
				if (wr_en || unsent == 32'd0)
					wait_cnt <= '0;
				else if (wait_cnt != 16'(tcp_pkg::WAIT_TICKS))
					wait_cnt <= wait_cnt + 16'd1;
				// runs only while something is in flight
				if (sent_seq == base_seq || seg_req)
					retx_cnt <= '0;
				else if (retx_cnt != 16'(tcp_pkg::RETX_TICKS))
					retx_cnt <= retx_cnt + 16'd1;
				if (seg_done)
					seg_req <= 1'b0;
				if (ack_v && acked != 32'd0 && acked <= used) begin
					base_seq <= ack_num;
					if (acked > sent_seq - base_seq)
						sent_seq <= ack_num; // ack overtook a rewound sent pointer
					retx_cnt <= '0;
				end else if (!seg_req && !seg_done && connected) begin
					if (retx_cnt == 16'(tcp_pkg::RETX_TICKS)) begin
						seg_req  <= 1'b1; // resend from base
						seg_seq  <= base_seq;
						seg_len  <= retx_len;
						sent_seq <= base_seq + 32'(retx_len);
						retx_cnt <= '0;
					end else if (unsent >= 32'(tcp_pkg::MSS) ||
							(unsent != 32'd0 && wait_cnt == 16'(tcp_pkg::WAIT_TICKS))) begin
						seg_req  <= 1'b1;
						seg_seq  <= sent_seq;
						seg_len  <= ready_len;
						sent_seq <= sent_seq + 32'(ready_len);
						wait_cnt <= '0;
					end
				end
			end
		end
	end

endmodule

/* verilog/tcp_tx_builder.sv */
module tcp_tx_builder (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         ctl_req,
	input  tcp_pkg::flags_t              ctl_flags,
	input  tcp_pkg::seq_t                snd_seq,
	input  tcp_pkg::seq_t                rcv_ack,
	input  tcp_pkg::port_t               rem_port,
	input  logic                         seg_req,
	input  tcp_pkg::seq_t                seg_seq,
	input  logic [15:0]                  seg_len,
	input  logic [7:0]                   rd_data,
	output logic [tcp_pkg::QUEUE_AW-1:0] rd_addr,
	output logic                         seg_done,
	output logic [7:0]                   tx_d,
	output logic                         tx_v,
	output logic                         tx_sof,
	output logic                         tx_eof
);

	logic            prep, sending; // two stage start, then byte stream
	logic            idle;
	logic            accept_ctl, accept_dat;
	logic            ctl_pend;      // control request seen while busy
	tcp_pkg::flags_t pend_flags;
	logic            is_data;
	logic [15:0]     cnt;           // index of next byte out
	logic [15:0]     last_idx;
	logic [7:0]      hb;            // header byte at cnt

	// latched header of the segment in progress
	tcp_pkg::flags_t h_flags;
	tcp_pkg::seq_t   h_seq;
	tcp_pkg::seq_t   h_ack;
	tcp_pkg::port_t  h_port;
	logic [15:0]     h_len;

	function automatic tcp_pkg::flags_t data_flags();
		tcp_pkg::flags_t f;
		f = '0;
		f[tcp_pkg::FLAG_ACK] = 1'b1;
		f[tcp_pkg::FLAG_PSH] = 1'b1;
		return f;
	endfunction

	assign idle       = !prep && !sending;
	assign accept_ctl = idle && (ctl_req || ctl_pend); // control wins
	// seg_done still high means the queue has not dropped seg_req yet
	assign accept_dat = idle && !accept_ctl && seg_req && !seg_done;
	assign last_idx   = 16'(tcp_pkg::HDR_BYTES - 1) + h_len;

	always_comb begin
		case (cnt)
			16'd0:   hb = tcp_pkg::LOC_PORT[15:8];
			16'd1:   hb = tcp_pkg::LOC_PORT[7:0];
			16'd2:   hb = h_port[15:8];
			16'd3:   hb = h_port[7:0];
			16'd4:   hb = h_seq[31:24];
			16'd5:   hb = h_seq[23:16];
			16'd6:   hb = h_seq[15:8];
			16'd7:   hb = h_seq[7:0];
			16'd8:   hb = h_ack[31:24];
			16'd9:   hb = h_ack[23:16];
			16'd10:  hb = h_ack[15:8];
			16'd11:  hb = h_ack[7:0];
			16'd12:  hb = 8'h50; // data offset 5 words
			16'd13:  hb = h_flags;
			16'd14:  hb = tcp_pkg::WINDOW[15:8];
			16'd15:  hb = tcp_pkg::WINDOW[7:0];
			default: hb = 8'h00; // checksum and urgent pointer
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prep     <= 1'b0;
			sending  <= 1'b0;
			ctl_pend <= 1'b0;
			seg_done <= 1'b0;
			tx_v     <= 1'b0;
			tx_sof   <= 1'b0;
			tx_eof   <= 1'b0;
		end else begin
			tx_v     <= 1'b0;
			tx_sof   <= 1'b0;
			tx_eof   <= 1'b0;
			seg_done <= 1'b0;
			if (ctl_req && !(idle && !ctl_pend))
				ctl_pend <= 1'b1; // served next
			else if (accept_ctl)
				ctl_pend <= 1'b0;
			if (accept_ctl || accept_dat)
				prep <= 1'b1;
			if (prep) begin
				prep    <= 1'b0;
				sending <= 1'b1;
			end
			if (sending) begin
				tx_v   <= 1'b1;
				tx_sof <= (cnt == 16'd0);
				if (cnt == last_idx) begin
					tx_eof   <= 1'b1;
					sending  <= 1'b0;
					seg_done <= is_data; // only data segments release the queue
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_req && !(idle && !ctl_pend))
			pend_flags <= ctl_flags;
		if (accept_ctl || accept_dat) begin
			is_data <= accept_dat;
			h_flags <= accept_dat ? data_flags() : (ctl_pend ? pend_flags : ctl_flags);
			h_seq   <= accept_dat ? seg_seq : snd_seq;
			h_ack   <= rcv_ack;
			h_port  <= rem_port;
			h_len   <= accept_dat ? seg_len : 16'd0;
			rd_addr <= tcp_pkg::buf_addr(seg_seq);
			cnt     <= '0;
		end
		if (sending) begin
			tx_d <= (cnt < 16'(tcp_pkg::HDR_BYTES)) ? hb : rd_data;
			cnt  <= cnt + 16'd1;
			if (cnt >= 16'(tcp_pkg::HDR_BYTES - 1))
				rd_addr <= rd_addr + 1'b1; // keep one address ahead of the output
		end
	end

endmodule

/* verilog/tcp_core.sv */
module tcp_core (
	input  logic       clk,
	input  logic       reset,
	input  logic       listen,
	input  logic [7:0] din,
	input  logic       vin,
	input  logic [7:0] rx_d,
	input  logic       rx_v,
	input  logic       rx_sof,
	input  logic       rx_eof,
	output logic       cts,
	output logic       connected,
	output logic [7:0] tx_d,
	output logic       tx_v,
	output logic       tx_sof,
	output logic       tx_eof
);

	// parser to fsm
	logic            hdr_v;
	tcp_pkg::port_t  src_port, dst_port;
	tcp_pkg::seq_t   rx_seq, rx_ack;
	tcp_pkg::flags_t rx_flags;
	logic [15:0]     rx_len;

	// fsm outputs
	logic            ctl_req;
	tcp_pkg::flags_t ctl_flags;
	tcp_pkg::seq_t   snd_seq, rcv_ack;
	tcp_pkg::port_t  rem_port;
	logic            ack_v;
	tcp_pkg::seq_t   ack_num;

	// queue and builder
	logic                         seg_req, seg_done;
	tcp_pkg::seq_t                seg_seq;
	logic [15:0]                  seg_len;
	logic [tcp_pkg::QUEUE_AW-1:0] rd_addr;
	logic [7:0]                   rd_data;

	tcp_rx_parser rx_parser (
		.clk(clk), .reset(reset),
		.rx_d(rx_d), .rx_v(rx_v), .rx_sof(rx_sof), .rx_eof(rx_eof),
		.hdr_v(hdr_v), .src_port(src_port), .dst_port(dst_port),
		.seg_seq(rx_seq), .seg_ack(rx_ack), .seg_flags(rx_flags), .seg_len(rx_len)
	);

	tcp_conn_fsm conn_fsm (
		.clk(clk), .reset(reset), .listen(listen),
		.hdr_v(hdr_v), .src_port(src_port), .dst_port(dst_port),
		.seg_seq(rx_seq), .seg_ack(rx_ack), .seg_flags(rx_flags), .seg_len(rx_len),
		.connected(connected), .ctl_req(ctl_req), .ctl_flags(ctl_flags),
		.snd_seq(snd_seq), .rcv_ack(rcv_ack), .rem_port(rem_port),
		.ack_v(ack_v), .ack_num(ack_num)
	);

	tcp_tx_queue tx_queue (
		.clk(clk), .reset(reset), .din(din), .vin(vin),
		.connected(connected), .ack_v(ack_v), .ack_num(ack_num),
		.rd_addr(rd_addr), .seg_done(seg_done), .cts(cts),
		.seg_req(seg_req), .seg_seq(seg_seq), .seg_len(seg_len), .rd_data(rd_data)
	);

	tcp_tx_builder tx_builder (
		.clk(clk), .reset(reset),
		.ctl_req(ctl_req), .ctl_flags(ctl_flags),
		.snd_seq(snd_seq), .rcv_ack(rcv_ack), .rem_port(rem_port),
		.seg_req(seg_req), .seg_seq(seg_seq), .seg_len(seg_len), .rd_data(rd_data),
		.rd_addr(rd_addr), .seg_done(seg_done),
		.tx_d(tx_d), .tx_v(tx_v), .tx_sof(tx_sof), .tx_eof(tx_eof)
	);

endmodule

/* sim/tcp_core_tb.sv */
module tcp_core_tb;

	logic       clk;
	logic       reset;
	logic       listen;
	logic [7:0] din;
	logic       vin;
	logic [7:0] rx_d;
	logic       rx_v, rx_sof, rx_eof;
	logic       cts, connected;
	logic [7:0] tx_d;
	logic       tx_v, tx_sof, tx_eof;

	// one step of the remote peer and what must come back
	typedef struct packed {
		int wr;     // user bytes written first
		int snd;    // 1 sends a remote segment
		int dport;
		int rflags;
		int rseq;   // offset from remote isn
		int rack;   // offset from our isn
		int plen;   // remote payload bytes
		int rsp;    // 0 nothing, 1 control segment, 2 data segments
		int eflags;
		int eseq;   // offset from our isn
		int eack;   // offset from remote isn
		int elen;   // total data bytes expected
		int conn;   // connected level afterwards
		int quiet;  // silent tx cycles at the end
		int tmo;    // cycles allowed per awaited segment
	} row_t;

	row_t           rows [0:10];
	tcp_pkg::seq_t  rem_isn;
	tcp_pkg::port_t rem_port;
	logic [7:0]     wdata [0:255];  // user stream indexed by seq - (isn+1)
	int             wr_total;
	logic [7:0]     cap_bytes [$];  // captured tx bytes
	int             cap_lens [$];   // lengths of finished segments
	int             cur_len;        // bytes of the open segment
	logic [7:0]     seg_buf [0:127];
	int             seg_n;

	tcp_core u_tcp_core (
		.clk(clk), .reset(reset), .listen(listen), .din(din), .vin(vin),
		.rx_d(rx_d), .rx_v(rx_v), .rx_sof(rx_sof), .rx_eof(rx_eof),
		.cts(cts), .connected(connected),
		.tx_d(tx_d), .tx_v(tx_v), .tx_sof(tx_sof), .tx_eof(tx_eof)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// tx monitor samples at the falling edge where outputs are stable
	always @(negedge clk) begin
		if (!reset && tx_v) begin
			if (tx_sof != (cur_len == 0)) begin
				$display("tx_sof missing at segment start or seen inside a segment");
				abort_run();
			end
			cap_bytes.push_back(tx_d);
			cur_len++;
			if (tx_eof) begin
				cap_lens.push_back(cur_len);
				cur_len = 0;
			end
		end
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_seq(input string name, input tcp_pkg::seq_t got,
			input tcp_pkg::seq_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_port(input string name, input tcp_pkg::port_t got,
			input tcp_pkg::port_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flags(input string name, input tcp_pkg::flags_t got,
			input tcp_pkg::flags_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// pop the next finished segment into seg_buf
	task automatic get_segment(input int tmo);
		int n;
		int len;
		n = 0;
		while (cap_lens.size() == 0) begin
			if (n == tmo) begin
				$display("timeout: no segment finished on tx within %0d cycles", tmo);
				abort_run();
			end
			@(negedge clk);
			n++;
		end
		len = cap_lens.pop_front();
		for (int i = 0; i < len; i++)
			seg_buf[i] = cap_bytes.pop_front();
		seg_n = len;
	endtask

	task automatic expect_quiet(input int cycles);
		if (cap_lens.size() != 0) begin
			$display("an extra segment came out on tx");
			abort_run();
		end
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (tx_v) begin
				$display("tx sent a segment where none was expected");
				abort_run();
			end
		end
	endtask

	task automatic wait_conn(input int exp);
		int n;
		n = 0;
		@(negedge clk);
		while (connected !== 1'(exp)) begin
			if (n == 100) begin
				$display("connected did not settle to %0d in time", exp);
				abort_run();
			end
			@(negedge clk);
			n++;
		end
	endtask

	// user bytes go one per cycle while cts allows
	task automatic write_user(input int n);
		int t;
		for (int i = 0; i < n; i++) begin
			t = 0;
			@(negedge clk);
			while (!cts) begin
				if (t == 1000) begin
					$display("cts stayed low, user byte could not be written");
					abort_run();
				end
				@(negedge clk);
				t++;
			end
			wdata[wr_total] = 8'($urandom);
			@(posedge clk);
			din <= wdata[wr_total];
			vin <= 1'b1;
			wr_total++;
		end
		@(posedge clk);
		vin <= 1'b0;
	endtask

	task automatic send_segment(input row_t r);
		logic [7:0]    b [0:127];
		tcp_pkg::seq_t sq;
		tcp_pkg::seq_t ak;
		int            n;
		sq = rem_isn + r.rseq;
		ak = tcp_pkg::ISN + r.rack;
		n = tcp_pkg::HDR_BYTES + r.plen;
		b[0] = rem_port[15:8];
		b[1] = rem_port[7:0];
		b[2] = 8'(r.dport >> 8);
		b[3] = 8'(r.dport);
		for (int i = 0; i < 4; i++) begin
			b[4 + i] = sq[31 - 8 * i -: 8]; // network order
			b[8 + i] = ak[31 - 8 * i -: 8];
		end
		b[12] = 8'h50;
		b[13] = 8'(r.rflags);
		b[14] = 8'h20; // remote window unused by the core
		b[15] = 8'h00;
		for (int i = 16; i < 20; i++)
			b[i] = 8'h00;
		for (int i = 0; i < r.plen; i++)
			b[tcp_pkg::HDR_BYTES + i] = 8'($urandom);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			rx_d   <= b[i];
			rx_v   <= 1'b1;
			rx_sof <= (i == 0);
			rx_eof <= (i == n - 1);
		end
		@(posedge clk);
		rx_v   <= 1'b0;
		rx_sof <= 1'b0;
		rx_eof <= 1'b0;
	endtask

	task automatic check_header(input int fl, input int sq, input int ak, input int len);
		check_len("tx payload length", 16'(seg_n - tcp_pkg::HDR_BYTES), 16'(len));
		check_port("tx src_port", {seg_buf[0], seg_buf[1]}, tcp_pkg::LOC_PORT);
		check_port("tx dst_port", {seg_buf[2], seg_buf[3]}, rem_port);
		check_seq("tx seq", {seg_buf[4], seg_buf[5], seg_buf[6], seg_buf[7]},
			tcp_pkg::ISN + sq);
		check_seq("tx ack", {seg_buf[8], seg_buf[9], seg_buf[10], seg_buf[11]},
			rem_isn + ak);
		check_byte("tx data offset", seg_buf[12], 8'h50);
		check_flags("tx flags", seg_buf[13], tcp_pkg::flags_t'(fl));
		check_len("tx window", {seg_buf[14], seg_buf[15]}, tcp_pkg::WINDOW);
		for (int i = 16; i < 20; i++)
			check_byte("tx checksum or urgent", seg_buf[i], 8'h00);
	endtask

	task automatic run_row(input row_t r);
		int off;
		int left;
		int n;
		if (r.wr != 0)
			write_user(r.wr);
		if (r.snd != 0)
			send_segment(r);
		if (r.rsp == 1) begin
			get_segment(r.tmo);
			check_header(r.eflags, r.eseq, r.eack, 0);
		end else if (r.rsp == 2) begin
			off = r.eseq;
			left = r.elen;
			while (left > 0) begin
				n = (left > tcp_pkg::MSS) ? tcp_pkg::MSS : left; // full segments first
				get_segment(r.tmo);
				check_header(r.eflags, off, r.eack, n);
				for (int i = 0; i < n; i++)
					check_byte("tx payload", seg_buf[tcp_pkg::HDR_BYTES + i], wdata[off - 1 + i]);
				off += n;
				left -= n;
			end
		end
		wait_conn(r.conn);
		expect_quiet(r.quiet);
	endtask

	initial begin
		reset    = 1'b1;
		listen   = 1'b0;
		din      = 8'h00;
		vin      = 1'b0;
		rx_d     = 8'h00;
		rx_v     = 1'b0;
		rx_sof   = 1'b0;
		rx_eof   = 1'b0;
		cur_len  = 0;
		wr_total = 0;
		void'($urandom(32674));
		rem_isn  = $urandom();
		rem_port = 16'hc351;

		// wr snd dport rflags rseq rack plen rsp eflags eseq eack elen conn quiet tmo
		rows[0]  = '{0, 1, 81, 'h02, 0, 0, 0, 0, 0, 0, 0, 0, 0, 100, 0};   // syn to port 81
		rows[1]  = '{0, 1, 80, 'h02, 0, 0, 0, 1, 'h12, 0, 1, 0, 0, 0, 200}; // syn gets syn|ack
		rows[2]  = '{0, 1, 80, 'h10, 1, 1, 0, 0, 0, 0, 0, 0, 1, 60, 0};
		rows[3]  = '{80, 0, 0, 0, 0, 0, 0, 2, 'h18, 1, 1, 80, 1, 0, 400};  // 64 + 16
		rows[4]  = '{0, 1, 80, 'h10, 1, 81, 0, 0, 0, 0, 0, 0, 1, 60, 0};
		rows[5]  = '{0, 1, 80, 'h18, 1, 81, 12, 1, 'h10, 81, 13, 0, 1, 0, 200};
		rows[6]  = '{10, 0, 0, 0, 0, 0, 0, 2, 'h18, 81, 13, 10, 1, 0, 400}; // left unacked
		rows[7]  = '{0, 0, 0, 0, 0, 0, 0, 2, 'h18, 81, 13, 10, 1, 0, 2 * tcp_pkg::RETX_TICKS};
		rows[8]  = '{0, 1, 80, 'h10, 13, 91, 0, 0, 0, 0, 0, 0, 1, tcp_pkg::RETX_TICKS + 200, 0};
		rows[9]  = '{0, 1, 80, 'h11, 13, 91, 0, 1, 'h11, 91, 14, 0, 1, 0, 200}; // remote fin
		rows[10] = '{0, 1, 80, 'h10, 14, 92, 0, 0, 0, 0, 0, 0, 0, 60, 0};

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		listen <= 1'b1; // rising edge arms the listener
		for (int k = 0; k <= 10; k++)
			run_row(rows[k]);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* list.f */
verilog/tcp_pkg.sv
verilog/tcp_rx_parser.sv
verilog/tcp_conn_fsm.sv
verilog/tcp_tx_queue.sv
verilog/tcp_tx_builder.sv
verilog/tcp_core.sv
sim/tcp_core_tb.sv

/* Makefile */
TOP = tcp_core_tb

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
